// File: rtl/gomoku_defines.svh
// board geometry, widths and pattern weights; include in any file that needs them
`ifndef GOMOKU_DEFINES_SVH
`define GOMOKU_DEFINES_SVH

// cells per side of the square board
`define GOMOKU_BOARD_SIZE 15

// rows first, then columns
`define GOMOKU_NUM_LINES 30

// signed score width
`define GOMOKU_SCORE_W 32

// per-line pattern count, a line holds at most 11 five-cell windows
`define GOMOKU_CNT_W 4

// weight added per matched window
`define GOMOKU_W_FIVE 32'd1000000

`define GOMOKU_W_OPEN_FOUR 32'd100000

// four stones with one end closed by the opponent
`define GOMOKU_W_BLOCKED_FOUR 32'd70000

`define GOMOKU_W_OPEN_THREE 32'd1000

`endif

// File: rtl/gomoku_pkg.sv
// shared stone, sequencer and pattern types; import wherever a module uses them
`include "gomoku_defines.svh"

package gomoku_pkg;

    // cell contents, reset value is empty
    typedef enum logic [1:0] {
        STONE_BLACK   = 2'd0,
        STONE_WHITE   = 2'd1,
        STONE_EMPTY   = 2'd2,
        STONE_INVALID = 2'd3
    } stone_t;

    // line sequencer in line_fetch
    typedef enum logic {
        S_IDLE = 1'b0,
        S_SCAN = 1'b1
    } scan_state_t;

    // index into the per-colour count arrays
    typedef enum logic [1:0] {
        PAT_FIVE         = 2'd0,
        PAT_OPEN_FOUR    = 2'd1,
        PAT_BLOCKED_FOUR = 2'd2,
        PAT_OPEN_THREE   = 2'd3
    } pattern_t;

    // one row or column, element j is cell j along the line
    typedef stone_t [`GOMOKU_BOARD_SIZE-1:0] line_t;

endpackage

// File: rtl/line_fetch.sv
// board storage and line sequencer; feeds one row or column per cycle to pattern_match
`timescale 1ns/100ps
`include "gomoku_defines.svh"

module line_fetch (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               wr_en_i,
    input  logic [3:0]         wr_row_i,
    input  logic [3:0]         wr_col_i,
    input  gomoku_pkg::stone_t wr_stone_i,
    input  logic               start_i,
    input  logic               done_i,
    output logic               busy_o,
    output logic               line_valid_o,
    output logic               line_last_o,
    output gomoku_pkg::line_t  line_o
);
    import gomoku_pkg::*;

    localparam int N = `GOMOKU_BOARD_SIZE;
    localparam logic [4:0] LAST_LINE = 5'(`GOMOKU_NUM_LINES - 1);

    stone_t      board [N][N];
    scan_state_t state;
    logic [4:0]  line_cnt;
    logic [3:0]  line_idx;
    logic        is_col;
    logic        busy_r;
    logic        accept;
    line_t       sel_line;

    // busy drops in the cycle done is high so the next start lands right after
    assign busy_o = busy_r && !done_i;
    assign accept = start_i && !busy_o;

    assign is_col   = (line_cnt >= 5'(N));
    assign line_idx = is_col ? 4'(line_cnt - 5'(N)) : line_cnt[3:0];

    always_comb begin
        for (int j = 0; j < N; j++) begin
            if (is_col) begin
                sel_line[j] = board[j][line_idx];
            end else begin
                sel_line[j] = board[line_idx][j];
            end
        end
    end

    // cell writes only while idle, off-board addresses dropped
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    board[r][c] <= STONE_EMPTY;
                end
            end
        end else if (wr_en_i && !busy_o && wr_row_i < 4'(N) && wr_col_i < 4'(N)) begin
            board[wr_row_i][wr_col_i] <= wr_stone_i;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_IDLE;
            line_cnt     <= '0;
            busy_r       <= 1'b0;
            line_valid_o <= 1'b0;
            line_last_o  <= 1'b0;
        end else begin
            line_valid_o <= 1'b0;
            line_last_o  <= 1'b0;

            if (accept) begin
                busy_r <= 1'b1;
            end else if (done_i) begin
                busy_r <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state    <= S_SCAN;
                        line_cnt <= '0;
                    end
                end
                S_SCAN: begin
                    line_valid_o <= 1'b1;
                    line_last_o  <= (line_cnt == LAST_LINE);
                    if (line_cnt == LAST_LINE) begin
                        state <= S_IDLE;
                    end else begin
                        line_cnt <= line_cnt + 5'd1;
                    end
                end
            endcase
        end
    end

    // line payload
    always_ff @(posedge i_clk) begin
        if (state == S_SCAN) begin
            line_o <= sel_line;
        end
    end

endmodule

// File: rtl/pattern_match.sv
// per-line pattern counter for both colours; one registered stage between fetch and accumulate
`timescale 1ns/100ps
`include "gomoku_defines.svh"

module pattern_match (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               line_valid_i,
    input  logic                               line_last_i,
    input  gomoku_pkg::line_t                  line_i,
    output logic                               cnt_valid_o,
    output logic                               cnt_last_o,
    output logic [3:0][`GOMOKU_CNT_W-1:0]      black_cnt_o,
    output logic [3:0][`GOMOKU_CNT_W-1:0]      white_cnt_o
);
    import gomoku_pkg::*;

    localparam int N  = `GOMOKU_BOARD_SIZE;
    localparam int CW = `GOMOKU_CNT_W;

    typedef logic [3:0][CW-1:0] cnt_set_t;

    cnt_set_t black_cnt;
    cnt_set_t white_cnt;

    // len cells starting at pos all hold the own colour
    function automatic logic is_run(input line_t ln, input int pos, input int len,
                                    input stone_t own);
        logic hit;
        hit = 1'b1;
        for (int k = 0; k < len; k++) begin
            if (ln[pos + k] != own) begin
                hit = 1'b0;
            end
        end
        return hit;
    endfunction

    function automatic cnt_set_t count_line(input line_t ln, input stone_t own,
                                            input stone_t opp);
        cnt_set_t c;
        c = '0;
        // five-cell windows
        for (int i = 0; i + 5 <= N; i++) begin
            if (is_run(ln, i, 5, own)) begin
                c[PAT_FIVE] = c[PAT_FIVE] + 1'b1;
            end
            if (ln[i] == STONE_EMPTY && is_run(ln, i + 1, 3, own) &&
                ln[i + 4] == STONE_EMPTY) begin
                c[PAT_OPEN_THREE] = c[PAT_OPEN_THREE] + 1'b1;
            end
        end
        // six-cell windows, both ends matter
        for (int i = 0; i + 6 <= N; i++) begin
            if (is_run(ln, i + 1, 4, own)) begin
                if (ln[i] == STONE_EMPTY && ln[i + 5] == STONE_EMPTY) begin
                    c[PAT_OPEN_FOUR] = c[PAT_OPEN_FOUR] + 1'b1;
                end else if ((ln[i] == STONE_EMPTY && ln[i + 5] == opp) ||
                             (ln[i] == opp && ln[i + 5] == STONE_EMPTY)) begin
                    c[PAT_BLOCKED_FOUR] = c[PAT_BLOCKED_FOUR] + 1'b1;
                end
            end
        end
        return c;
    endfunction

    assign black_cnt = count_line(line_i, STONE_BLACK, STONE_WHITE);
    assign white_cnt = count_line(line_i, STONE_WHITE, STONE_BLACK);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_valid_o <= 1'b0;
            cnt_last_o  <= 1'b0;
        end else begin
            cnt_valid_o <= line_valid_i;
            cnt_last_o  <= line_valid_i && line_last_i;
        end
    end

    // per-colour counts for the line just matched
    always_ff @(posedge i_clk) begin
        black_cnt_o <= black_cnt;
        white_cnt_o <= white_cnt;
    end

endmodule

// File: rtl/score_accum.sv
// weights line counts into per-colour totals and outputs the side-to-move score with done
`timescale 1ns/100ps
`include "gomoku_defines.svh"

module score_accum (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                start_i,
    input  logic                                turn_i,
    input  logic                                cnt_valid_i,
    input  logic                                cnt_last_i,
    input  logic [3:0][`GOMOKU_CNT_W-1:0]       black_cnt_i,
    input  logic [3:0][`GOMOKU_CNT_W-1:0]       white_cnt_i,
    output logic signed [`GOMOKU_SCORE_W-1:0]   score_o,
    output logic                                done_o
);
    import gomoku_pkg::*;

    typedef logic signed [`GOMOKU_SCORE_W-1:0] score_t;

    score_t black_tot;
    score_t white_tot;
    score_t black_line;
    score_t white_line;
    logic   turn_r;
    logic   last_r;

    function automatic score_t weigh(input logic [3:0][`GOMOKU_CNT_W-1:0] c);
        score_t w;
        w = score_t'(c[PAT_FIVE] * `GOMOKU_W_FIVE);
        w = w + score_t'(c[PAT_OPEN_FOUR] * `GOMOKU_W_OPEN_FOUR);
        w = w + score_t'(c[PAT_BLOCKED_FOUR] * `GOMOKU_W_BLOCKED_FOUR);
        w = w + score_t'(c[PAT_OPEN_THREE] * `GOMOKU_W_OPEN_THREE);
        return w;
    endfunction

    assign black_line = weigh(black_cnt_i);
    assign white_line = weigh(white_cnt_i);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            black_tot <= '0;
            white_tot <= '0;
            turn_r    <= 1'b0;
            last_r    <= 1'b0;
            score_o   <= '0;
            done_o    <= 1'b0;
        end else begin
            last_r <= cnt_valid_i && cnt_last_i;
            done_o <= last_r;

            // start never overlaps valid counts, the scan is idle then
            if (start_i) begin
                black_tot <= '0;
                white_tot <= '0;
                turn_r    <= turn_i;
            end else if (cnt_valid_i) begin
                black_tot <= black_tot + black_line;
                white_tot <= white_tot + white_line;
            end

            // turn 1 means white to move
            if (last_r) begin
                score_o <= turn_r ? (white_tot - black_tot) : (black_tot - white_tot);
            end
        end
    end

endmodule

// File: rtl/board_eval_top.sv
// top level of the board evaluator; connects fetch, match and accumulate stages
`timescale 1ns/100ps
`include "gomoku_defines.svh"

module board_eval_top (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              wr_en_i,
    input  logic [3:0]                        wr_row_i,
    input  logic [3:0]                        wr_col_i,
    input  gomoku_pkg::stone_t                wr_stone_i,
    input  logic                              start_i,
    input  logic                              turn_i,
    output logic                              busy_o,
    output logic signed [`GOMOKU_SCORE_W-1:0] score_o,
    output logic                              done_o
);
    import gomoku_pkg::*;

    line_t                          line;
    logic                           line_valid;
    logic                           line_last;
    logic                           cnt_valid;
    logic                           cnt_last;
    logic [3:0][`GOMOKU_CNT_W-1:0]  black_cnt;
    logic [3:0][`GOMOKU_CNT_W-1:0]  white_cnt;
    logic                           start_acc;

    // only an accepted start clears the totals
    assign start_acc = start_i && !busy_o;

    line_fetch u_fetch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .wr_en_i      (wr_en_i),
        .wr_row_i     (wr_row_i),
        .wr_col_i     (wr_col_i),
        .wr_stone_i   (wr_stone_i),
        .start_i      (start_i),
        .done_i       (done_o),
        .busy_o       (busy_o),
        .line_valid_o (line_valid),
        .line_last_o  (line_last),
        .line_o       (line)
    );

    pattern_match u_match (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .line_valid_i (line_valid),
        .line_last_i  (line_last),
        .line_i       (line),
        .cnt_valid_o  (cnt_valid),
        .cnt_last_o   (cnt_last),
        .black_cnt_o  (black_cnt),
        .white_cnt_o  (white_cnt)
    );

    score_accum u_accum (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .start_i     (start_acc),
        .turn_i      (turn_i),
        .cnt_valid_i (cnt_valid),
        .cnt_last_i  (cnt_last),
        .black_cnt_i (black_cnt),
        .white_cnt_i (white_cnt),
        .score_o     (score_o),
        .done_o      (done_o)
    );

endmodule

// File: tb/tb_clock.sv
// clock and reset source for the testbench, 100 ns period with reset held low for 16 cycles
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// File: tb/board_eval_props.sv
// protocol assertions for the board evaluator, bound into board_eval_top
`timescale 1ns/100ps
`include "gomoku_defines.svh"

module board_eval_props (
    input logic                              i_clk,
    input logic                              i_rst_n,
    input logic                              start_i,
    input logic                              busy_i,
    input logic                              done_i,
    input logic                              line_valid_i,
    input logic signed [`GOMOKU_SCORE_W-1:0] score_i
);

    logic [5:0] edges;
    logic       armed;
    int         err_timing = 0;
    int         err_orphan = 0;
    int         err_width  = 0;
    int         err_reset  = 0;
    int         err_ignore = 0;
    int         fail_total;

    assign fail_total = err_timing + err_orphan + err_width + err_reset + err_ignore;

    // edges since the accepted start
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            edges <= '0;
            armed <= 1'b0;
        end else if (start_i && !busy_i) begin
            edges <= '0;
            armed <= 1'b1;
        end else if (done_i) begin
            armed <= 1'b0;
        end else if (armed) begin
            edges <= edges + 6'd1;
        end
    end

    a_done_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        armed |-> (done_i == (edges == 6'd33)))
    else begin
        err_timing++;
        $error("done not 33 edges after the accepted start");
    end

    a_done_orphan: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        done_i |-> armed)
    else begin
        err_orphan++;
        $error("done without an accepted start");
    end

    a_done_width: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        done_i |=> !done_i)
    else begin
        err_width++;
        $error("done held for more than one cycle");
    end

    a_reset_idle: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> (!busy_i && !done_i && score_i == '0))
    else begin
        err_reset++;
        $error("outputs not idle after reset");
    end

    // lines 0..29 leave fetch on edges 1..30, a start while busy must not add more
    a_busy_ignore: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (start_i && busy_i) |=>
            (armed && (line_valid_i == (edges >= 6'd1 && edges <= 6'd30))))
    else begin
        err_ignore++;
        $error("start while busy restarted the scan");
    end

endmodule

bind board_eval_top board_eval_props u_props (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .start_i      (start_i),
    .busy_i       (busy_o),
    .done_i       (done_o),
    .line_valid_i (line_valid),
    .score_i      (score_o)
);

// File: tb/board_eval_tb.sv
// testbench for the board evaluator; loads boards, runs evaluations and checks scores against a model
`timescale 1ns/100ps
`include "gomoku_defines.svh"

module board_eval_tb;
    import gomoku_pkg::*;

    localparam int N           = `GOMOKU_BOARD_SIZE;
    localparam int NUM_TESTS   = 27;
    localparam int DONE_WAIT   = 100;
    localparam int WATCHDOG_NS = NUM_TESTS * (N * N + 40) * 100 * 2;

    logic                              clk;
    logic                              rst_n;
    logic                              wr_en;
    logic [3:0]                        wr_row;
    logic [3:0]                        wr_col;
    stone_t                            wr_stone;
    logic                              start;
    logic                              turn;
    logic                              busy;
    logic                              done;
    logic signed [`GOMOKU_SCORE_W-1:0] score;

    stone_t      model_board [N][N];
    logic [31:0] rng_state;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          check_errors = 0;
    int          done_count   = 0;

    tb_clock u_clk (.clk_o(clk), .rst_n_o(rst_n));

    board_eval_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .wr_en_i    (wr_en),
        .wr_row_i   (wr_row),
        .wr_col_i   (wr_col),
        .wr_stone_i (wr_stone),
        .start_i    (start),
        .turn_i     (turn),
        .busy_o     (busy),
        .score_o    (score),
        .done_o     (done)
    );

    always @(negedge clk) begin
        if (rst_n && done) begin
            done_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // weighted pattern sum for one colour in one line
    function automatic longint line_value(input logic [N-1:0] own, input logic [N-1:0] emp,
                                          input logic [N-1:0] opp);
        longint v;
        v = 0;
        for (int p = 0; p <= N - 5; p++) begin
            if (own[p +: 5] == 5'b11111) begin
                v += longint'(`GOMOKU_W_FIVE);
            end
            if (emp[p] && own[p + 1 +: 3] == 3'b111 && emp[p + 4]) begin
                v += longint'(`GOMOKU_W_OPEN_THREE);
            end
        end
        for (int p = 0; p <= N - 6; p++) begin
            if (own[p + 1 +: 4] == 4'hf) begin
                if (emp[p] && emp[p + 5]) begin
                    v += longint'(`GOMOKU_W_OPEN_FOUR);
                end
                if ((emp[p] && opp[p + 5]) || (opp[p] && emp[p + 5])) begin
                    v += longint'(`GOMOKU_W_BLOCKED_FOUR);
                end
            end
        end
        return v;
    endfunction

    function automatic longint board_score(input logic side);
        longint       blk;
        longint       wht;
        logic [N-1:0] bk;
        logic [N-1:0] wh;
        logic [N-1:0] em;
        stone_t       s;
        blk = 0;
        wht = 0;
        // rows 0..14 then columns
        for (int k = 0; k < 2 * N; k++) begin
            for (int j = 0; j < N; j++) begin
                s     = (k < N) ? model_board[k][j] : model_board[j][k - N];
                bk[j] = (s == STONE_BLACK);
                wh[j] = (s == STONE_WHITE);
                em[j] = (s == STONE_EMPTY);
            end
            blk += line_value(bk, em, wh);
            wht += line_value(wh, em, bk);
        end
        return side ? (wht - blk) : (blk - wht);
    endfunction

    task automatic clear_model();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                model_board[r][c] = STONE_EMPTY;
            end
        end
    endtask

    task automatic place_run(input int r, input int c, input int dr, input int dc,
                             input int len, input stone_t s);
        for (int k = 0; k < len; k++) begin
            model_board[r + k * dr][c + k * dc] = s;
        end
    endtask

    // copies the whole model board into the DUT, one cell per cycle
    task automatic load_board();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                @(negedge clk);
                wr_en    = 1'b1;
                wr_row   = 4'(r);
                wr_col   = 4'(c);
                wr_stone = model_board[r][c];
            end
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("timeout: no done pulse within %0d cycles of start", DONE_WAIT);
            check_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (check_errors != errs_before) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: pass", tests_run, name);
        end
    endtask

    task automatic check_board(input string name, input logic side);
        logic signed [`GOMOKU_SCORE_W-1:0] got;
        longint                            expected;
        int                                errs_before;
        errs_before = check_errors;
        expected    = board_score(side);
        @(negedge clk);
        start = 1'b1;
        turn  = side;
        @(negedge clk);
        start = 1'b0;
        wait_done();
        got = score;
        assert (longint'(got) == expected) else begin
            $display("Mismatch at %0t ns: %s score %0d, model %0d", $time, name, got, expected);
            check_errors++;
        end
        finish_test(name, errs_before);
    endtask

    task automatic check_busy_ignore();
        logic signed [`GOMOKU_SCORE_W-1:0] got;
        longint                            expected;
        int                                errs_before;
        int                                pulses_before;
        errs_before   = check_errors;
        expected      = board_score(1'b0);
        pulses_before = done_count;
        @(negedge clk);
        start = 1'b1;
        turn  = 1'b0;
        @(negedge clk);
        assert (busy) else begin
            $display("Mismatch at %0t ns: busy low after an accepted start", $time);
            check_errors++;
        end
        // restart requests up to the edge before done, a black five on row 7 early on
        for (int i = 0; i < `GOMOKU_NUM_LINES + 2; i++) begin
            turn     = 1'b1;
            wr_en    = (i < 5);
            wr_row   = 4'd7;
            wr_col   = 4'(i % 5);
            wr_stone = STONE_BLACK;
            @(negedge clk);
        end
        start = 1'b0;
        wr_en = 1'b0;
        wait_done();
        got = score;
        assert (longint'(got) == expected) else begin
            $display("Mismatch at %0t ns: busy score %0d, model %0d", $time, got, expected);
            check_errors++;
        end
        repeat (40) @(negedge clk);
        assert (done_count - pulses_before == 1) else begin
            $display("Mismatch at %0t ns: %0d done pulses, expected 1", $time,
                     done_count - pulses_before);
            check_errors++;
        end
        finish_test("start and writes while busy", errs_before);
    endtask

    initial begin
        int          errs_before;
        logic [31:0] rnd;
        wr_en     = 1'b0;
        wr_row    = 4'd0;
        wr_col    = 4'd0;
        wr_stone  = STONE_EMPTY;
        start     = 1'b0;
        turn      = 1'b0;
        rng_state = 32'd99460;
        clear_model();
        @(posedge rst_n);
        @(negedge clk);

        errs_before = check_errors;
        assert (!busy && !done && score == 0) else begin
            $display("Mismatch at %0t ns: after reset busy %b done %b score %0d", $time,
                     busy, done, score);
            check_errors++;
        end
        finish_test("reset values", errs_before);
        check_board("empty board", 1'b0);

        place_run(3, 4, 0, 1, 5, STONE_BLACK);
        place_run(3, 10, 0, 1, 1, STONE_WHITE);
        place_run(9, 6, 1, 0, 3, STONE_WHITE);
        load_board();
        check_board("row five black to move", 1'b0);
        check_board("row five white to move", 1'b1);

        // open four, then blocked fours closed below and above
        clear_model();
        place_run(2, 10, 1, 0, 4, STONE_WHITE);
        place_run(6, 12, 1, 0, 4, STONE_WHITE);
        place_run(10, 12, 1, 0, 1, STONE_BLACK);
        place_run(8, 1, 1, 0, 4, STONE_WHITE);
        place_run(7, 1, 1, 0, 1, STONE_BLACK);
        load_board();
        check_board("column fours", 1'b0);

        clear_model();
        place_run(12, 3, 0, 1, 3, STONE_BLACK);
        place_run(2, 0, 1, 0, 3, STONE_WHITE);
        place_run(0, 9, 0, 1, 3, STONE_WHITE);
        place_run(9, 14, 1, 0, 3, STONE_BLACK);
        load_board();
        check_board("open threes", 1'b1);

        for (int t = 0; t < 20; t++) begin
            for (int r = 0; r < N; r++) begin
                for (int c = 0; c < N; c++) begin
                    rnd = next_rand() % 8;
                    model_board[r][c] = (rnd < 2) ? STONE_BLACK :
                                        (rnd < 4) ? STONE_WHITE : STONE_EMPTY;
                end
            end
            load_board();
            rnd = next_rand();
            check_board($sformatf("random board %0d", t), rnd[0]);
        end

        clear_model();
        place_run(2, 10, 1, 0, 4, STONE_WHITE);
        place_run(12, 3, 0, 1, 3, STONE_BLACK);
        load_board();
        check_busy_ignore();

        $display("tests run %0d, passed %0d, failed %0d, bound assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, dut.u_props.fail_total);
        if (tests_failed == 0 && dut.u_props.fail_total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/gomoku_pkg.sv
rtl/line_fetch.sv
rtl/pattern_match.sv
rtl/score_accum.sv
rtl/board_eval_top.sv
tb/tb_clock.sv
tb/board_eval_props.sv
tb/board_eval_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the board evaluator testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module board_eval_tb \
    -o board_eval_sim
out=$(./obj_dir/board_eval_sim +verilator+error+limit+1000) || true
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
